// File: logic/xbar_track_pkg.sv
`default_nettype none

package xbar_track_pkg;

  parameter int NUM_CH   = 3;
  // Fixed by the two-bit bank field
  parameter int NUM_BANK = 4;
  parameter int CNT_W    = 10;

  // Request addresses carry bits 31 down to ADDR_LSB
  parameter int ADDR_LSB = 4;
  // Bank select sits in address bits 9:8
  parameter int BANK_LSB = 8;

  typedef enum logic [2:0] {
    OP_READ     = 3'd0,
    OP_WRITE    = 3'd1,
    OP_ATOMIC   = 3'd2,
    OP_PREFETCH = 3'd3,
    OP_FLUSH    = 3'd4
  } mem_op_e;

  // APB map
  // Counter of channel c, bank b at byte address 4 * (c * NUM_BANK + b)
  parameter logic [31:0] APB_STATUS_ADDR = 32'h0000_0030;

endpackage

`default_nettype wire

// File: logic/read_event_decode.sv
`timescale 1ns/1ns
`default_nettype none

module read_event_decode
  import xbar_track_pkg::*;
#(
  parameter int NUM_CH = xbar_track_pkg::NUM_CH
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic    [NUM_CH-1:0]                 req_valid_i,
  input  logic    [NUM_CH-1:0]                 req_ready_i,
  input  mem_op_e [NUM_CH-1:0]                 req_op_i,
  input  logic    [NUM_CH-1:0][31:ADDR_LSB]    req_addr_i,
  input  logic    [NUM_CH-1:0]                 rtn_valid_i,
  input  logic    [NUM_CH-1:0][1:0]            rtn_bank_i,
  output logic    [NUM_CH-1:0][NUM_BANK-1:0]   inc_q_o,
  output logic    [NUM_CH-1:0][NUM_BANK-1:0]   dec_q_o
);

  logic [NUM_CH-1:0][NUM_BANK-1:0] inc_d;
  logic [NUM_CH-1:0][NUM_BANK-1:0] dec_d;
  logic [NUM_CH-1:0]               rd_accept;

  // Each channel qualifies with its own opcode
  always_comb begin
    for (int c = 0; c < NUM_CH; c++) begin
      rd_accept[c] = req_valid_i[c] & req_ready_i[c] & (req_op_i[c] == OP_READ);
    end
  end

  always_comb begin
    inc_d = '0;
    dec_d = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      if (rd_accept[c]) begin
        inc_d[c][req_addr_i[c][BANK_LSB+1:BANK_LSB]] = 1'b1;
      end
      // Returns are never stalled
      if (rtn_valid_i[c]) begin
        dec_d[c][rtn_bank_i[c]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      inc_q_o <= '0;
      dec_q_o <= '0;
    end else begin
      inc_q_o <= inc_d;
      dec_q_o <= dec_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/outstanding_counters.sv
`timescale 1ns/1ns
`default_nettype none

module outstanding_counters
  import xbar_track_pkg::*;
#(
  parameter int NUM_CH = xbar_track_pkg::NUM_CH,
  parameter int CNT_W  = xbar_track_pkg::CNT_W
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [NUM_CH-1:0][NUM_BANK-1:0]     inc_i,
  input  logic [NUM_CH-1:0][NUM_BANK-1:0]     dec_i,
  input  logic [NUM_CH-1:0]                   clr_underflow_i,
  output logic [NUM_CH*NUM_BANK*CNT_W-1:0]    counts_o,
  output logic [NUM_CH-1:0]                   underflow_o
);

  logic [NUM_CH-1:0][NUM_BANK-1:0][CNT_W-1:0] cnt_q;
  logic [NUM_CH-1:0][NUM_BANK-1:0][CNT_W-1:0] cnt_d;
  logic [NUM_CH-1:0]                          uf_q;
  logic [NUM_CH-1:0]                          uf_hit;

  // Increment and decrement act on their own banks
  always_comb begin
    cnt_d  = cnt_q;
    uf_hit = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      for (int b = 0; b < NUM_BANK; b++) begin
        if (dec_i[c][b] && !inc_i[c][b]) begin
          if (cnt_q[c][b] == '0) begin
            // Hold at zero, flag the channel
            uf_hit[c] = 1'b1;
          end else begin
            cnt_d[c][b] = cnt_q[c][b] - 1'b1;
          end
        end else if (inc_i[c][b] && !dec_i[c][b]) begin
          cnt_d[c][b] = cnt_q[c][b] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Sticky, a new underflow wins over a clear
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      uf_q <= '0;
    end else begin
      uf_q <= (uf_q & ~clr_underflow_i) | uf_hit;
    end
  end

  assign counts_o    = cnt_q;
  assign underflow_o = uf_q;

endmodule

`default_nettype wire

// File: logic/apb_count_regs.sv
`timescale 1ns/1ns
`default_nettype none

module apb_count_regs
  import xbar_track_pkg::*;
#(
  parameter int NUM_CH = xbar_track_pkg::NUM_CH,
  parameter int CNT_W  = xbar_track_pkg::CNT_W
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [31:0]                       paddr_i,
  input  logic [31:0]                       pwdata_i,
  input  logic [NUM_CH*NUM_BANK*CNT_W-1:0]  counts_i,
  input  logic [NUM_CH-1:0]                 underflow_i,
  output logic [31:0]                       prdata_o,
  output logic                              pslverr_o,
  output logic [NUM_CH-1:0]                 clr_underflow_o
);

  localparam int NUM_REGS = NUM_CH * NUM_BANK;

  logic             access;
  logic [31:0]      word_idx;
  logic             is_status;
  logic             cnt_hit;
  logic [CNT_W-1:0] cnt_val;

  assign access    = psel_i & penable_i;
  assign word_idx  = {2'b00, paddr_i[31:2]};
  assign is_status = (paddr_i == APB_STATUS_ADDR);

  // Counter select, word aligned only
  always_comb begin
    cnt_hit = 1'b0;
    cnt_val = '0;
    for (int r = 0; r < NUM_REGS; r++) begin
      if (paddr_i[1:0] == 2'b00 && word_idx == r) begin
        cnt_hit = 1'b1;
        cnt_val = counts_i[r*CNT_W +: CNT_W];
      end
    end
  end

  always_comb begin
    prdata_o  = '0;
    pslverr_o = 1'b0;
    if (access) begin
      if (is_status) begin
        if (!pwrite_i) prdata_o[NUM_CH-1:0] = underflow_i;
      end else if (cnt_hit) begin
        if (!pwrite_i) prdata_o[CNT_W-1:0] = cnt_val;
      end else begin
        pslverr_o = 1'b1;
      end
    end
  end

  // W1C pulse, loaded at the edge closing the access phase
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      clr_underflow_o <= '0;
    end else if (access && pwrite_i && is_status) begin
      clr_underflow_o <= pwdata_i[NUM_CH-1:0];
    end else begin
      clr_underflow_o <= '0;
    end
  end

endmodule

`default_nettype wire

// File: logic/read_tracker_top.sv
`timescale 1ns/1ns
`default_nettype none

module read_tracker_top
  import xbar_track_pkg::*;
#(
  parameter int NUM_CH = xbar_track_pkg::NUM_CH,
  parameter int CNT_W  = xbar_track_pkg::CNT_W
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic    [NUM_CH-1:0]              req_valid_i,
  input  logic    [NUM_CH-1:0]              req_ready_i,
  input  mem_op_e [NUM_CH-1:0]              req_op_i,
  input  logic    [NUM_CH-1:0][31:ADDR_LSB] req_addr_i,
  input  logic    [NUM_CH-1:0]              rtn_valid_i,
  input  logic    [NUM_CH-1:0][1:0]         rtn_bank_i,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic    [31:0]                    paddr_i,
  input  logic    [31:0]                    pwdata_i,
  output logic    [31:0]                    prdata_o,
  output logic                              pslverr_o
);

  logic [NUM_CH-1:0][NUM_BANK-1:0]  inc_q;
  logic [NUM_CH-1:0][NUM_BANK-1:0]  dec_q;
  logic [NUM_CH*NUM_BANK*CNT_W-1:0] counts;
  logic [NUM_CH-1:0]                underflow;
  logic [NUM_CH-1:0]                clr_underflow;

  read_event_decode #(
    .NUM_CH (NUM_CH)
  ) read_event_decode_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .rtn_valid_i (rtn_valid_i),
    .rtn_bank_i  (rtn_bank_i),
    .inc_q_o     (inc_q),
    .dec_q_o     (dec_q)
  );

  outstanding_counters #(
    .NUM_CH (NUM_CH),
    .CNT_W  (CNT_W)
  ) outstanding_counters_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .inc_i           (inc_q),
    .dec_i           (dec_q),
    .clr_underflow_i (clr_underflow),
    .counts_o        (counts),
    .underflow_o     (underflow)
  );

  apb_count_regs #(
    .NUM_CH (NUM_CH),
    .CNT_W  (CNT_W)
  ) apb_count_regs_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .counts_i        (counts),
    .underflow_i     (underflow),
    .prdata_o        (prdata_o),
    .pslverr_o       (pslverr_o),
    .clr_underflow_o (clr_underflow)
  );

endmodule

`default_nettype wire

// File: testbench/read_tracker_sva.sv
`timescale 1ns/1ns
`default_nettype none

module read_tracker_sva
  import xbar_track_pkg::*;
#(
  parameter int NUM_CH = xbar_track_pkg::NUM_CH,
  parameter int CNT_W  = xbar_track_pkg::CNT_W
) (
  input logic                             clk_i,
  input logic                             rst_i,
  input logic [NUM_CH*NUM_BANK*CNT_W-1:0] counts_o,
  input logic [NUM_CH-1:0]                underflow_o,
  input logic [NUM_CH-1:0]                clr_underflow_i
);

  for (genvar r = 0; r < NUM_CH * NUM_BANK; r++) begin : g_cnt
    logic [CNT_W-1:0] cur;
    logic [CNT_W-1:0] prev;
    logic [CNT_W-1:0] delta;

    assign cur   = counts_o[r*CNT_W +: CNT_W];
    assign delta = cur - prev;

    always_ff @(posedge clk_i) begin
      prev <= cur;
    end

    // Up one, down one or unchanged
    a_step: assert property (@(posedge clk_i) disable iff (rst_i)
      (delta == '0) || (delta == CNT_W'(1)) || (delta == '1))
      else $error("counter %0d moved by more than one", r);
  end

  for (genvar c = 0; c < NUM_CH; c++) begin : g_uf
    a_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
      $fell(underflow_o[c]) |-> $past(clr_underflow_i[c]))
      else $error("underflow flag %0d fell without a clear", c);
  end

  a_reset: assert property (@(posedge clk_i) $fell(rst_i) |-> (counts_o == '0))
    else $error("counters not zero after reset");

endmodule

bind outstanding_counters read_tracker_sva #(
  .NUM_CH (NUM_CH),
  .CNT_W  (CNT_W)
) read_tracker_sva_i (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .counts_o        (counts_o),
  .underflow_o     (underflow_o),
  .clr_underflow_i (clr_underflow_i)
);

`default_nettype wire

// File: testbench/tb_read_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_read_tracker
  import xbar_track_pkg::*;
;

  localparam int STIM_CYCLES = 2000;
  // Stimulus plus reset checks and the last transfers
  localparam int TIMEOUT     = 3000;

  logic                            clk_i;
  logic                            rst_i;
  logic [NUM_CH-1:0]               req_valid_i;
  logic [NUM_CH-1:0]               req_ready_i;
  mem_op_e [NUM_CH-1:0]            req_op_i;
  logic [NUM_CH-1:0][31:ADDR_LSB]  req_addr_i;
  logic [NUM_CH-1:0]               rtn_valid_i;
  logic [NUM_CH-1:0][1:0]          rtn_bank_i;
  logic                            psel_i;
  logic                            penable_i;
  logic                            pwrite_i;
  logic [31:0]                     paddr_i;
  logic [31:0]                     pwdata_i;
  logic [31:0]                     prdata_o;
  logic                            pslverr_o;

  // Reference model state
  logic [CNT_W-1:0]                model_cnt [NUM_CH][NUM_BANK];
  logic [NUM_CH-1:0]               model_uf;
  logic [NUM_CH-1:0][NUM_BANK-1:0] pend_inc;
  logic [NUM_CH-1:0][NUM_BANK-1:0] pend_dec;
  logic [NUM_CH-1:0][NUM_BANK-1:0] s1_inc;
  logic [NUM_CH-1:0][NUM_BANK-1:0] s1_dec;
  logic [NUM_CH-1:0]               pend_clr;
  logic [NUM_CH-1:0]               s1_clr;
  logic                            traffic_en;
  int                              cycle_cnt;
  int                              error_cnt;

  read_tracker_top #(
    .NUM_CH (NUM_CH),
    .CNT_W  (CNT_W)
  ) read_tracker_top_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .rtn_valid_i (rtn_valid_i),
    .rtn_bank_i  (rtn_bank_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pslverr_o   (pslverr_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Run did not complete within %0d cycles", TIMEOUT);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  task automatic check_count(string name, logic [CNT_W-1:0] got, logic [CNT_W-1:0] exp);
    if (got !== exp) begin
      error_cnt++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_status(string name, logic [NUM_CH-1:0] got, logic [NUM_CH-1:0] exp);
    if (got !== exp) begin
      error_cnt++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "status mismatch");
    end
  endtask

  task automatic check_err(string name, logic got, logic exp);
    if (got !== exp) begin
      error_cnt++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "bit mismatch");
    end
  endtask

  // Counter rule applied to events that reach the counters at this edge
  function automatic void apply_events(logic [NUM_CH-1:0][NUM_BANK-1:0] inc,
                                       logic [NUM_CH-1:0][NUM_BANK-1:0] dec,
                                       logic [NUM_CH-1:0] clr);
    logic [NUM_CH-1:0] hit;
    hit = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      for (int b = 0; b < NUM_BANK; b++) begin
        if (dec[c][b] && !inc[c][b]) begin
          if (model_cnt[c][b] == '0) hit[c] = 1'b1;
          else model_cnt[c][b] = model_cnt[c][b] - 1'b1;
        end else if (inc[c][b] && !dec[c][b]) begin
          model_cnt[c][b] = model_cnt[c][b] + 1'b1;
        end
      end
    end
    model_uf = (model_uf & ~clr) | hit;
  endfunction

  // One clock: advance the model pipeline, drive traffic and APB
  task automatic step(logic sel, logic en, logic wr, logic [31:0] addr, logic [31:0] wdata);
    @(posedge clk_i);
    #1;
    apply_events(s1_inc, s1_dec, s1_clr);
    s1_inc = pend_inc;
    s1_dec = pend_dec;
    s1_clr = pend_clr;
    pend_inc = '0;
    pend_dec = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      req_valid_i[c] = traffic_en && ($urandom % 4 != 0);
      req_ready_i[c] = ($urandom % 4 != 0);
      req_op_i[c]    = ($urandom % 2 == 0) ? OP_READ : mem_op_e'(3'(1 + $urandom % 4));
      req_addr_i[c]  = 28'($urandom);
      rtn_valid_i[c] = traffic_en && ($urandom % 3 == 0);
      rtn_bank_i[c]  = 2'($urandom);
      if (req_valid_i[c] && req_ready_i[c] && req_op_i[c] == OP_READ)
        pend_inc[c][req_addr_i[c][BANK_LSB+1:BANK_LSB]] = 1'b1;
      if (rtn_valid_i[c])
        pend_dec[c][rtn_bank_i[c]] = 1'b1;
    end
    psel_i    = sel;
    penable_i = en;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    pend_clr  = (sel && en && wr && addr == APB_STATUS_ADDR) ? wdata[NUM_CH-1:0] : '0;
  endtask

  // Ends inside the access phase, the caller returns the bus to idle
  task automatic apb_read(logic [31:0] addr, output logic [31:0] data, output logic err);
    step(1'b1, 1'b0, 1'b0, addr, 32'h0);
    #5;
    // Outputs stay quiet in the setup phase
    check_err("pslverr_o in setup", pslverr_o, 1'b0);
    check_err("prdata_o in setup", |prdata_o, 1'b0);
    step(1'b1, 1'b1, 1'b0, addr, 32'h0);
    #5;
    data = prdata_o;
    err  = pslverr_o;
  endtask

  task automatic apb_write_status(logic [31:0] wdata);
    step(1'b1, 1'b0, 1'b1, APB_STATUS_ADDR, wdata);
    step(1'b1, 1'b1, 1'b1, APB_STATUS_ADDR, wdata);
    step(1'b0, 1'b0, 1'b0, 32'h0, 32'h0);
  endtask

  task automatic read_counter(int c, int b);
    logic [31:0] data;
    logic        err;
    apb_read(32'(4 * (c * NUM_BANK + b)), data, err);
    check_count($sformatf("prdata_o count[%0d][%0d]", c, b), data[CNT_W-1:0], model_cnt[c][b]);
    check_err("prdata_o upper bits", |data[31:CNT_W], 1'b0);
    check_err("pslverr_o", err, 1'b0);
    step(1'b0, 1'b0, 1'b0, 32'h0, 32'h0);
  endtask

  task automatic read_status();
    logic [31:0] data;
    logic        err;
    apb_read(APB_STATUS_ADDR, data, err);
    check_status("prdata_o status", data[NUM_CH-1:0], model_uf);
    check_err("pslverr_o", err, 1'b0);
    step(1'b0, 1'b0, 1'b0, 32'h0, 32'h0);
  endtask

  task automatic read_unmapped();
    logic [31:0] addr;
    logic [31:0] data;
    logic        err;
    if ($urandom % 2 == 0) addr = 32'(4 * ($urandom % 13)) + 32'(1 + $urandom % 3);
    else addr = 32'h34 + 32'(4 * ($urandom % 1000));
    apb_read(addr, data, err);
    check_err("pslverr_o", err, 1'b1);
    check_count("prdata_o on error", data[CNT_W-1:0], '0);
    check_err("prdata_o upper bits", |data[31:CNT_W], 1'b0);
    step(1'b0, 1'b0, 1'b0, 32'h0, 32'h0);
  endtask

  initial begin
    void'($urandom(32'hdb8148b5));
    clk_i = 1'b0;
    rst_i = 1'b1;
    req_valid_i = '0;
    req_ready_i = '0;
    for (int c = 0; c < NUM_CH; c++)
      req_op_i[c] = OP_READ;
    req_addr_i  = '0;
    rtn_valid_i = '0;
    rtn_bank_i  = '0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    traffic_en = 1'b0;
    cycle_cnt = 0;
    error_cnt = 0;
    model_uf = '0;
    pend_inc = '0;
    pend_dec = '0;
    s1_inc = '0;
    s1_dec = '0;
    pend_clr = '0;
    s1_clr = '0;
    for (int c = 0; c < NUM_CH; c++)
      for (int b = 0; b < NUM_BANK; b++)
        model_cnt[c][b] = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Quiet bus after reset
    for (int c = 0; c < NUM_CH; c++)
      for (int b = 0; b < NUM_BANK; b++)
        read_counter(c, b);
    read_status();

    traffic_en = 1'b1;
    while (cycle_cnt < STIM_CYCLES) begin
      repeat (1 + $urandom % 4) step(1'b0, 1'b0, 1'b0, 32'h0, 32'h0);
      case ($urandom % 6)
        0: begin
          read_status();
          apb_write_status(32'($urandom));
        end
        1: read_unmapped();
        default: read_counter($urandom % NUM_CH, $urandom % NUM_BANK);
      endcase
    end

    // Drain and sweep every register
    traffic_en = 1'b0;
    repeat (4) step(1'b0, 1'b0, 1'b0, 32'h0, 32'h0);
    for (int c = 0; c < NUM_CH; c++)
      for (int b = 0; b < NUM_BANK; b++)
        read_counter(c, b);
    read_status();

    if (error_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
logic/xbar_track_pkg.sv
logic/read_event_decode.sv
logic/outstanding_counters.sv
logic/apb_count_regs.sv
logic/read_tracker_top.sv
testbench/read_tracker_sva.sv
testbench/tb_read_tracker.sv

// File: Makefile
TOP = tb_read_tracker

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
